// File: design/rv_pkg.sv
package rv_pkg;

    // --------------------------------------------------
    // Widths and reset address
    // --------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;  // First fetch address

    // --------------------------------------------------
    // Major opcodes from instruction bits 6 to 2
    // --------------------------------------------------
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        STORE  = 5'b01000,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011,
        OTHER  = 5'b11111   // Anything not kept retires as a no-op
    } mopcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Sequencer states with one instruction in flight
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_e;

    // Transfer size coded as funct3[1:0]
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } tsize_e;

endpackage

// File: design/rv_stage_if.sv
`timescale 1ns/10ps

interface rv_stage_if import rv_pkg::*; ();

    // Decoded bundle
    mopcode_e              opcode;
    logic [2:0]            funct3;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_wr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // Execute results
    logic [XLEN-1:0]       alu_out;
    logic [XLEN-1:0]       mem_addr;
    logic [XLEN-1:0]       next_pc;

    // Phase strobes
    logic                  decode_en;
    logic                  execute_en;
    logic                  wb_en;

    modport decode (output opcode, funct3, alu_op, imm, rd, rf_wr, rs1_data, rs2_data,
                    input decode_en);
    modport execute (input opcode, funct3, alu_op, imm, rs1_data, rs2_data, execute_en,
                     output alu_out, mem_addr, next_pc);
    modport result (input opcode, funct3, imm, rd, rf_wr, alu_out, wb_en);
    modport sequencer (input opcode, next_pc, output decode_en, execute_en, wb_en);

endinterface

// File: design/rv_alu.sv
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
    input  alu_op_e         op_i,
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    output logic [XLEN-1:0] result_o,
    output logic            carry_o,
    output logic            negative_o,
    output logic            zero_o,
    output logic            overflow_o
);

    logic [XLEN-1:0] diff;
    logic [4:0]      shamt;

    // a - b as a + ~b + 1
    // Carry out set means no borrow
    assign {carry_o, diff} = {1'b0, a_i} + {1'b0, ~b_i} + 33'd1;
    assign negative_o = diff[XLEN-1];
    assign zero_o     = (diff == '0);
    assign overflow_o = (a_i[XLEN-1] != b_i[XLEN-1]) && (diff[XLEN-1] != a_i[XLEN-1]);

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = diff;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {31'b0, negative_o ^ overflow_o};
            ALU_SLTU:   result_o = {31'b0, ~carry_o};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;  // LUI
            default:    result_o = '0;
        endcase
    end

endmodule

// File: design/rv_sequencer.sv
`timescale 1ns/10ps

module rv_sequencer import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic            ibus_req_o,
    output logic [XLEN-1:0] ibus_addr_o,
    input  logic            ibus_done_i,
    input  logic [XLEN-1:0] ibus_rdata_i,
    output logic            dbus_req_o,
    output logic            dbus_we_o,
    input  logic            dbus_done_i,
    output logic [XLEN-1:0] instr_o,
    output logic [XLEN-1:0] pc_o,
    rv_stage_if.sequencer   stage
);

    core_state_e     state, state_nxt;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr_q;

    // --------------------------------------------------
    // State stepping
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            FETCH:     if (ibus_done_i) state_nxt = DECODE;
            DECODE:    state_nxt = EXECUTE;
            EXECUTE: begin
                // Memory phase only for loads and stores
                if (stage.opcode == LOAD || stage.opcode == STORE)
                    state_nxt = MEMORY;
                else
                    state_nxt = WRITEBACK;
            end
            MEMORY:    if (dbus_done_i) state_nxt = WRITEBACK;
            WRITEBACK: state_nxt = FETCH;
            default:   state_nxt = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == WRITEBACK)
                pc <= stage.next_pc;  // Retire
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (state == FETCH && ibus_done_i)
            instr_q <= ibus_rdata_i;
    end

    // --------------------------------------------------
    // Strobes and bus requests
    // --------------------------------------------------
    assign stage.decode_en  = (state == DECODE);
    assign stage.execute_en = (state == EXECUTE);
    assign stage.wb_en      = (state == WRITEBACK);

    assign ibus_req_o  = (state == FETCH);
    assign ibus_addr_o = pc;
    assign dbus_req_o  = (state == MEMORY);
    assign dbus_we_o   = (state == MEMORY) && (stage.opcode == STORE);

    assign instr_o = instr_q;
    assign pc_o    = pc;

endmodule

// File: design/rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [XLEN-1:0]       instr_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    rv_stage_if.decode            stage
);

    mopcode_e              opc;
    logic [2:0]            f3;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    alu_op_e               op;
    logic                  wr;

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign f3         = instr_i[14:12];
    assign rd         = instr_i[11:7];

    // Non-32-bit encodings fall into OTHER
    always_comb begin
        opc = OTHER;
        if (instr_i[1:0] == 2'b11) begin
            case (instr_i[6:2])
                LOAD, OP_IMM, AUIPC, STORE, OP, LUI, BRANCH, JALR, JAL:
                    opc = mopcode_e'(instr_i[6:2]);
                default: opc = OTHER;
            endcase
        end
    end

    // --------------------------------------------------
    // Immediate formats
    // --------------------------------------------------
    always_comb begin
        case (opc)
            LOAD, OP_IMM, JALR: imm = {{20{instr_i[31]}}, instr_i[31:20]};
            STORE:  imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            BRANCH: imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                           instr_i[30:25], instr_i[11:8], 1'b0};
            LUI, AUIPC: imm = {instr_i[31:12], 12'b0};
            JAL:    imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                           instr_i[20], instr_i[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // ALU operation from funct3 and funct7 bit 5
    always_comb begin
        op = ALU_ADD;
        if (opc == OP || opc == OP_IMM) begin
            case (f3)
                3'b000: op = (opc == OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
                3'b001: op = ALU_SLL;
                3'b010: op = ALU_SLT;
                3'b011: op = ALU_SLTU;
                3'b100: op = ALU_XOR;
                3'b101: op = instr_i[30] ? ALU_SRA : ALU_SRL;
                3'b110: op = ALU_OR;
                default: op = ALU_AND;
            endcase
        end else if (opc == BRANCH) begin
            op = ALU_SUB;     // Compare through the flags
        end else if (opc == LUI) begin
            op = ALU_PASS_B;
        end
    end

    assign wr = (opc inside {LOAD, OP_IMM, AUIPC, OP, LUI, JALR, JAL}) && (rd != '0);

    // --------------------------------------------------
    // Registered bundle
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage.opcode <= OTHER;
            stage.funct3 <= '0;
            stage.alu_op <= ALU_ADD;
            stage.rd     <= '0;
            stage.rf_wr  <= 1'b0;
        end else if (stage.decode_en) begin
            stage.opcode <= opc;
            stage.funct3 <= f3;
            stage.alu_op <= op;
            stage.rd     <= rd;
            stage.rf_wr  <= wr;
        end
    end

    always_ff @(posedge clk) begin
        if (stage.decode_en) begin
            stage.imm      <= imm;
            stage.rs1_data <= rs1_data_i;
            stage.rs2_data <= rs2_data_i;
        end
    end

endmodule

// File: design/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [REG_ADDR_W-1:0] rd_addr_i,
    input  logic                  wr_en_i,
    input  logic [XLEN-1:0]       wr_data_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // No storage behind x0
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= wr_data_i;
        end
    end

    // Asynchronous read ports
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: design/rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] pc_i,
    output logic [XLEN-1:0] dbus_addr_o,
    output logic [XLEN-1:0] dbus_wdata_o,
    output tsize_e          dbus_size_o,
    rv_stage_if.execute     stage
);

    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_res;
    logic            c, n, z, v;
    logic [XLEN-1:0] addr_sum;
    logic            taken;
    logic [XLEN-1:0] npc;

    // Immediate operand for OP_IMM and LUI
    assign alu_b = (stage.opcode inside {OP_IMM, LUI}) ? stage.imm : stage.rs2_data;

    rv_alu i_alu (
        .op_i       (stage.alu_op),
        .a_i        (stage.rs1_data),
        .b_i        (alu_b),
        .result_o   (alu_res),
        .carry_o    (c),
        .negative_o (n),
        .zero_o     (z),
        .overflow_o (v)
    );

    assign addr_sum = stage.rs1_data + stage.imm;  // Load, store and JALR target

    // --------------------------------------------------
    // Branch decision and next PC
    // --------------------------------------------------
    always_comb begin
        case (stage.funct3)
            3'b000:  taken = z;          // BEQ
            3'b001:  taken = !z;         // BNE
            3'b100:  taken = n ^ v;      // BLT
            3'b101:  taken = !(n ^ v);   // BGE
            3'b110:  taken = !c;         // BLTU
            3'b111:  taken = c;          // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (stage.opcode)
            BRANCH:  npc = taken ? pc_i + stage.imm : pc_i + 32'd4;
            JAL:     npc = pc_i + stage.imm;
            JALR:    npc = {addr_sum[XLEN-1:1], 1'b0};
            default: npc = pc_i + 32'd4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            stage.next_pc <= RESET_PC;
        else if (stage.execute_en)
            stage.next_pc <= npc;
    end

    // Results held through MEMORY and WRITEBACK
    always_ff @(posedge clk) begin
        if (stage.execute_en) begin
            stage.alu_out  <= alu_res;
            stage.mem_addr <= addr_sum;
            dbus_wdata_o   <= stage.rs2_data;  // Full rs2 value unshifted
            dbus_size_o    <= tsize_e'(stage.funct3[1:0]);
        end
    end

    assign dbus_addr_o = stage.mem_addr;

endmodule

// File: design/rv_result.sv
`timescale 1ns/10ps

module rv_result import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dbus_done_i,
    input  logic [XLEN-1:0]       dbus_rdata_i,
    input  logic [XLEN-1:0]       pc_i,
    output logic [REG_ADDR_W-1:0] rd_addr_o,
    output logic                  wr_en_o,
    output logic [XLEN-1:0]       wr_data_o,
    rv_stage_if.result            stage
);

    logic [XLEN-1:0] load_q;
    logic [XLEN-1:0] load_ext;

    // Right-aligned read data taken in the done cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            load_q <= '0;
        else if (dbus_done_i)
            load_q <= dbus_rdata_i;
    end

    always_comb begin
        case (stage.funct3)
            3'b000:  load_ext = {{24{load_q[7]}}, load_q[7:0]};    // LB
            3'b001:  load_ext = {{16{load_q[15]}}, load_q[15:0]};  // LH
            3'b100:  load_ext = {24'b0, load_q[7:0]};              // LBU
            3'b101:  load_ext = {16'b0, load_q[15:0]};             // LHU
            default: load_ext = load_q;                            // LW
        endcase
    end

    // --------------------------------------------------
    // Writeback value
    // --------------------------------------------------
    always_comb begin
        case (stage.opcode)
            LOAD:            wr_data_o = load_ext;
            OP, OP_IMM, LUI: wr_data_o = stage.alu_out;
            AUIPC:           wr_data_o = pc_i + stage.imm;
            JAL, JALR:       wr_data_o = pc_i + 32'd4;  // Link address
            default:         wr_data_o = '0;
        endcase
    end

    assign rd_addr_o = stage.rd;
    assign wr_en_o   = stage.rf_wr && stage.wb_en;

endmodule

// File: design/rv_core.sv
`timescale 1ns/10ps

module rv_core import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    // Instruction bus
    output logic            ibus_req_o,
    output logic [XLEN-1:0] ibus_addr_o,
    input  logic            ibus_done_i,
    input  logic [XLEN-1:0] ibus_rdata_i,
    // Data bus
    output logic            dbus_req_o,
    output logic            dbus_we_o,
    output tsize_e          dbus_size_o,
    output logic [XLEN-1:0] dbus_addr_o,
    output logic [XLEN-1:0] dbus_wdata_o,
    input  logic            dbus_done_i,
    input  logic [XLEN-1:0] dbus_rdata_i
);

    logic [XLEN-1:0]       instr, pc;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data, wr_data;
    logic                  wr_en;

    rv_stage_if stage ();

    rv_sequencer i_sequencer (
        .clk, .rst_n, .ibus_req_o, .ibus_addr_o, .ibus_done_i, .ibus_rdata_i,
        .dbus_req_o, .dbus_we_o, .dbus_done_i,
        .instr_o (instr), .pc_o (pc), .stage (stage.sequencer)
    );

    rv_decode i_decode (
        .clk, .rst_n, .instr_i (instr),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data), .rs2_data_i (rs2_data), .stage (stage.decode)
    );

    rv_regfile i_regfile (
        .clk, .rst_n, .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rd_addr_i (rd_addr), .wr_en_i (wr_en), .wr_data_i (wr_data),
        .rs1_data_o (rs1_data), .rs2_data_o (rs2_data)
    );

    rv_execute i_execute (
        .clk, .rst_n, .pc_i (pc), .dbus_addr_o, .dbus_wdata_o, .dbus_size_o,
        .stage (stage.execute)
    );

    rv_result i_result (
        .clk, .rst_n, .dbus_done_i, .dbus_rdata_i, .pc_i (pc),
        .rd_addr_o (rd_addr), .wr_en_o (wr_en), .wr_data_o (wr_data),
        .stage (stage.result)
    );

endmodule

// File: tb/rv_core_sva.sv
`timescale 1ns/10ps

module rv_core_sva import rv_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            ibus_req_o,
    input logic [XLEN-1:0] ibus_addr_o,
    input logic            ibus_done_i,
    input logic            dbus_req_o,
    input logic            dbus_we_o,
    input logic            dbus_done_i,
    input core_state_e     state
);

    // Requests held until done
    a_ireq_held: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_req_o && !ibus_done_i |=> ibus_req_o && $stable(ibus_addr_o))
        else $error("I-bus request dropped or address moved before done");

    a_dreq_held: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_req_o && !dbus_done_i |=> dbus_req_o && $stable(dbus_we_o))
        else $error("D-bus request dropped before done");

    a_dreq_state: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(dbus_req_o) |-> $past(state) == EXECUTE)
        else $error("D-bus request not started from EXECUTE");

    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !dbus_req_o && !dbus_we_o)
        else $error("D-bus active in the first cycle after reset");

endmodule

bind rv_sequencer rv_core_sva i_sva (
    .clk, .rst_n, .ibus_req_o, .ibus_addr_o, .ibus_done_i,
    .dbus_req_o, .dbus_we_o, .dbus_done_i, .state (state)
);

// File: tb/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb import rv_pkg::*; ();

    logic            clk, rst_n;
    logic            ibus_req_o, ibus_done_i, dbus_req_o, dbus_we_o, dbus_done_i;
    logic [XLEN-1:0] ibus_addr_o, ibus_rdata_i, dbus_addr_o, dbus_wdata_o, dbus_rdata_i;
    tsize_e          dbus_size_o;

    logic [31:0] mem [0:4095];      // Word array seen by the DUT
    logic [31:0] ref_mem [0:4095];  // Architectural copy
    logic [31:0] lfsr_q = 32'hb029;
    logic [31:0] exp_fetch [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    tsize_e      exp_st_size [$];
    int          pc_w, st_off, fetch_cnt, i_wait, d_wait;
    bit          finished;

    rv_core i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------
    // Random bits and instruction encoding
    // --------------------------------------------------
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[pc_w] = w;
        pc_w++;
    endtask

    task automatic emit_store(input logic [4:0] rs, input logic [2:0] f3);
        emit(enc_s(st_off[11:0], rs, 5'd3, f3));
        st_off += 4;
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit({hi[31:12], rd, 7'h37});
        emit(enc_i(v[11:0], rd, 3'b000, rd, 7'h13));
    endtask

    // --------------------------------------------------
    // Reference model running the program architecturally
    // --------------------------------------------------
    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        w = ref_mem[a[13:2]];
        return w[8*a[1:0] +: 8];
    endfunction

    function automatic void ref_run();
        logic [31:0] x [0:31];
        logic [31:0] pc, npc, ins, a, b, r, ii, is, ib, ij, addr, w;
        logic [2:0]  f3;
        logic [31:0] t;
        bit          take;
        for (int k = 0; k < 32; k++)
            x[k] = '0;
        pc = RESET_PC;
        for (int step = 0; step < 10000; step++) begin
            ins = ref_mem[pc[13:2]];
            exp_fetch.push_back(pc);
            f3  = ins[14:12];
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            ii  = {{20{ins[31]}}, ins[31:20]};
            is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            ib  = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            ij  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            npc = pc + 4;
            r   = '0;
            case (ins[6:0])
                7'h37: r = {ins[31:12], 12'b0};
                7'h17: r = pc + {ins[31:12], 12'b0};
                7'h6f: begin
                    r   = pc + 4;
                    npc = pc + ij;
                end
                7'h67: begin
                    r   = pc + 4;
                    t   = a + ii;
                    npc = {t[31:1], 1'b0};
                end
                7'h63: begin
                    case (f3)
                        3'b000:  take = (a == b);
                        3'b001:  take = (a != b);
                        3'b100:  take = ($signed(a) < $signed(b));
                        3'b101:  take = ($signed(a) >= $signed(b));
                        3'b110:  take = (a < b);
                        3'b111:  take = (a >= b);
                        default: take = 1'b0;
                    endcase
                    if (take) npc = pc + ib;
                end
                7'h03: begin
                    addr = a + ii;
                    for (int k = 0; k < 4; k++)
                        w[8*k +: 8] = ref_byte(addr + k);
                    case (f3)
                        3'b000:  r = {{24{w[7]}}, w[7:0]};
                        3'b001:  r = {{16{w[15]}}, w[15:0]};
                        3'b100:  r = {24'b0, w[7:0]};
                        3'b101:  r = {16'b0, w[15:0]};
                        default: r = w;
                    endcase
                end
                7'h23: begin
                    addr = a + is;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                    exp_st_size.push_back(tsize_e'(f3[1:0]));
                    for (int k = 0; k < (1 << f3[1:0]); k++) begin
                        t = addr + k;
                        ref_mem[t[13:2]][8*t[1:0] +: 8] = b[8*k +: 8];
                    end
                end
                7'h13, 7'h33: begin
                    if (ins[6:0] == 7'h13) b = ii;
                    case (f3)
                        3'b000:  r = (ins[5] && ins[30]) ? a - b : a + b;
                        3'b001:  r = a << b[4:0];
                        3'b010:  r = {31'b0, $signed(a) < $signed(b)};
                        3'b011:  r = {31'b0, a < b};
                        3'b100:  r = a ^ b;
                        3'b101: begin
                            if (ins[30])
                                r = $signed(a) >>> b[4:0];
                            else
                                r = a >> b[4:0];
                        end
                        3'b110:  r = a | b;
                        default: r = a & b;
                    endcase
                end
                default: ;  // No-op
            endcase
            if (ins[6:0] inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h03, 7'h13, 7'h33}
                && ins[11:7] != 5'd0)
                x[ins[11:7]] = r;
            if (ins[6:0] == 7'h6f && npc == pc)
                return;  // Self-jump ends the program
            pc = npc;
        end
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_addr(input logic [XLEN-1:0] got, exp);
        if (got !== exp) begin
            $display("TEST FAILED");
            $display("Mismatch at %0t: fetch address %h, expected %h", $time, got, exp);
            $fatal(1);
        end
    endtask

    task automatic check_store(input logic [XLEN-1:0] addr, data, input tsize_e size,
                               input logic [XLEN-1:0] e_addr, e_data, input tsize_e e_size);
        if (addr !== e_addr || data !== e_data || size !== e_size) begin
            $display("TEST FAILED");
            $display("Mismatch at %0t: store %h <= %h size %s, expected %h <= %h size %s",
                     $time, addr, data, size.name(), e_addr, e_data, e_size.name());
            $fatal(1);
        end
    endtask

    task automatic fail_plain(input string msg);
        $display("TEST FAILED");
        $display("%s", msg);
        $fatal(1);
    endtask

    // Compare process sampled on the rising edge
    always @(posedge clk) begin
        if (rst_n && !finished && ibus_req_o && ibus_done_i) begin
            if (exp_fetch.size() == 0)
                fail_plain("Fetch seen after the expected program end");
            check_addr(ibus_addr_o, exp_fetch.pop_front());
            fetch_cnt++;
            if (exp_fetch.size() == 0)
                finished = 1'b1;
        end
        if (rst_n && !finished && dbus_req_o && dbus_we_o && dbus_done_i) begin
            if (exp_st_addr.size() == 0)
                fail_plain("Store seen that the program does not make");
            check_store(dbus_addr_o, dbus_wdata_o, dbus_size_o, exp_st_addr.pop_front(),
                        exp_st_data.pop_front(), exp_st_size.pop_front());
        end
    end

    // Memory model with 0 to 3 wait cycles per transfer
    always @(negedge clk) begin
        logic [31:0] a;
        ibus_done_i = 1'b0;
        dbus_done_i = 1'b0;
        if (rst_n && ibus_req_o) begin
            if (i_wait < 0) i_wait = take_bits(2);
            if (i_wait == 0) begin
                ibus_done_i  = 1'b1;
                ibus_rdata_i = mem[ibus_addr_o[13:2]];
            end
            i_wait--;
        end
        if (rst_n && dbus_req_o) begin
            if (d_wait < 0) d_wait = take_bits(2);
            if (d_wait == 0) begin
                dbus_done_i = 1'b1;
                for (int k = 0; k < 4; k++) begin
                    a = dbus_addr_o + k;
                    if (dbus_we_o && k < (1 << dbus_size_o))
                        mem[a[13:2]][8*a[1:0] +: 8] = dbus_wdata_o[8*k +: 8];
                    dbus_rdata_i[8*k +: 8] = mem[a[13:2]][8*a[1:0] +: 8];
                end
            end
            d_wait--;
        end
    end

    // --------------------------------------------------
    // Program, reset and run
    // --------------------------------------------------
    initial begin
        logic [2:0] br_f3 [6];
        int cycles, idle, last_cnt;
        br_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        rst_n = 1'b0;
        ibus_done_i = 1'b0;
        ibus_rdata_i = '0;
        dbus_done_i = 1'b0;
        dbus_rdata_i = '0;
        i_wait = -1;
        d_wait = -1;
        fetch_cnt = 0;
        finished = 1'b0;
        for (int k = 0; k < 4096; k++)
            mem[k] = {k[15:0] ^ 16'ha5c3, ~k[15:0]};
        mem[2048] = 32'h8f7e_c3a5;  // Load data at 0x2000
        mem[2049] = 32'h1234_f0e9;
        pc_w = 0;
        st_off = 0;
        load_const(5'd1, take_bits(32));
        load_const(5'd2, take_bits(32));
        emit({20'h00001, 5'd3, 7'h37});  // Store base 0x1000
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd5));
            emit_store(5'd5, 3'b010);
            if (f == 0 || f == 5) begin
                emit(enc_r(7'h20, 5'd2, 5'd1, f[2:0], 5'd5));
                emit_store(5'd5, 3'b010);
            end
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5)
                emit(enc_i({7'h00, 5'(take_bits(5))}, 5'd1, f[2:0], 5'd5, 7'h13));
            else
                emit(enc_i(12'(take_bits(12)), 5'd1, f[2:0], 5'd5, 7'h13));
            emit_store(5'd5, 3'b010);
        end
        emit(enc_i({7'h20, 5'(take_bits(5))}, 5'd1, 3'b101, 5'd5, 7'h13));  // SRAI
        emit_store(5'd5, 3'b010);
        emit({20'(take_bits(20)), 5'd6, 7'h37});
        emit_store(5'd6, 3'b010);
        emit({20'(take_bits(20)), 5'd7, 7'h17});
        emit_store(5'd7, 3'b010);
        emit(enc_i(12'd5, 5'd1, 3'b000, 5'd0, 7'h13));  // Write to x0
        emit_store(5'd0, 3'b010);
        for (int k = 0; k < 6; k++) begin
            emit(enc_b(13'd8, 5'd2, 5'd1, br_f3[k]));
            emit(enc_i(12'd1, 5'd8, 3'b000, 5'd8, 7'h13));
            emit(enc_b(13'd8, 5'd1, 5'd1, br_f3[k]));
            emit(enc_i(12'd1, 5'd8, 3'b000, 5'd8, 7'h13));
        end
        emit_store(5'd8, 3'b010);
        emit(enc_j(21'd8, 5'd9));
        emit(enc_i(12'd1, 5'd8, 3'b000, 5'd8, 7'h13));
        emit_store(5'd9, 3'b010);
        emit({20'h0, 5'd10, 7'h17});
        emit(enc_i(12'd13, 5'd10, 3'b000, 5'd11, 7'h67));  // Odd target
        emit(enc_i(12'd1, 5'd8, 3'b000, 5'd8, 7'h13));
        emit_store(5'd11, 3'b010);
        emit_store(5'd8, 3'b010);
        emit({20'h00002, 5'd13, 7'h37});
        emit(enc_i(12'd1, 5'd13, 3'b000, 5'd12, 7'h03));
        emit_store(5'd12, 3'b010);
        emit(enc_i(12'd2, 5'd13, 3'b001, 5'd12, 7'h03));
        emit_store(5'd12, 3'b010);
        emit(enc_i(12'd4, 5'd13, 3'b010, 5'd12, 7'h03));
        emit_store(5'd12, 3'b010);
        emit(enc_i(12'd3, 5'd13, 3'b100, 5'd12, 7'h03));
        emit_store(5'd12, 3'b010);
        emit(enc_i(12'd2, 5'd13, 3'b101, 5'd12, 7'h03));
        emit_store(5'd12, 3'b010);
        emit_store(5'd1, 3'b000);
        emit_store(5'd1, 3'b001);
        emit(enc_j(21'd0, 5'd0));
        for (int k = 0; k < 4096; k++)
            ref_mem[k] = mem[k];
        ref_run();

        repeat (5) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
        cycles = 0;
        idle = 0;
        last_cnt = 0;
        while (!finished) begin
            @(posedge clk);
            cycles++;
            idle = (fetch_cnt != last_cnt) ? 0 : idle + 1;
            last_cnt = fetch_cnt;
            if (idle > 200)
                fail_plain("Timeout: the core stopped fetching instructions");
            if (cycles > 50000)
                fail_plain("Timeout: the program did not reach its final self-jump");
        end
        if (exp_st_addr.size() != 0) begin
            $display("TEST FAILED");
            $display("Program ended with %0d expected stores missing", exp_st_addr.size());
            $fatal(1);
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// File: rv_core.f
design/rv_pkg.sv
design/rv_stage_if.sv
design/rv_alu.sv
design/rv_sequencer.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/rv_stage_if.sv
  - design/rv_alu.sv
  - design/rv_sequencer.sv
  - design/rv_decode.sv
  - design/rv_regfile.sv
  - design/rv_execute.sv
  - design/rv_result.sv
  - design/rv_core.sv
  - target: test
    files:
      - tb/rv_core_sva.sv
      - tb/rv_core_tb.sv
